// File: Makefile
# Verilator build for the HyperBus uDMA channel testbench

VERILATOR ?= verilator
TOP       ?= tb_hyper_udma_chan
FILELIST  ?= sim.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert -Wno-fatal
JOBS      ?= 4

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build and run the testbench with Verilator"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST BUILD_DIR VFLAGS JOBS"

test:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)

// File: rtl/hyper_udma_chan.sv
// HyperBus uDMA channel front end
// Config registers, TX and RX stream engines around a 4 KB L2 buffer

`default_nettype none

module hyper_udma_chan (
    input  wire logic        sys_clk,
    input  wire logic        rst_n,
    input  wire logic [4:0]  cfg_addr_i,
    input  wire logic [31:0] cfg_data_i,
    input  wire logic        cfg_valid_i,
    input  wire logic        cfg_rwn_i,
    output wire logic [31:0] cfg_data_o,
    output wire logic [31:0] tx_data_o,
    output wire logic        tx_valid_o,
    input  wire logic        tx_ready_i,
    output wire logic        tx_eot_o,
    input  wire logic [31:0] rx_data_i,
    input  wire logic        rx_valid_i,
    output wire logic        rx_eot_o
);

    udma_pkg::l2_addr_t mem_raddr;
    udma_pkg::word_t    mem_rdata;
    logic               mem_we;
    udma_pkg::l2_addr_t mem_waddr;
    udma_pkg::word_t    mem_wdata;

    udma_chan_if tx_chan ();
    udma_chan_if rx_chan ();

    udma_cfg_regs udma_cfg_regs_i (
        .sys_clk     (sys_clk),
        .rst_n       (rst_n),
        .cfg_addr_i  (cfg_addr_i),
        .cfg_data_i  (cfg_data_i),
        .cfg_valid_i (cfg_valid_i),
        .cfg_rwn_i   (cfg_rwn_i),
        .cfg_data_o  (cfg_data_o),
        .tx_chan     (tx_chan.regs),
        .rx_chan     (rx_chan.regs)
    );

    udma_tx_stream udma_tx_stream_i (
        .sys_clk     (sys_clk),
        .rst_n       (rst_n),
        .chan        (tx_chan.engine),
        .mem_raddr_o (mem_raddr),
        .mem_rdata_i (mem_rdata),
        .tx_ready_i  (tx_ready_i),
        .tx_data_o   (tx_data_o),
        .tx_valid_o  (tx_valid_o),
        .tx_eot_o    (tx_eot_o)
    );

    udma_rx_stream udma_rx_stream_i (
        .sys_clk     (sys_clk),
        .rst_n       (rst_n),
        .rx_data_i   (rx_data_i),
        .rx_valid_i  (rx_valid_i),
        .chan        (rx_chan.engine),
        .mem_we_o    (mem_we),
        .mem_waddr_o (mem_waddr),
        .mem_wdata_o (mem_wdata),
        .rx_eot_o    (rx_eot_o)
    );

    l2_byte_mem l2_byte_mem_i (
        .sys_clk (sys_clk),
        .raddr_i (mem_raddr),
        .rdata_o (mem_rdata),
        .we_i    (mem_we),
        .waddr_i (mem_waddr),
        .wdata_i (mem_wdata)
    );

endmodule

`default_nettype wire

// File: rtl/l2_byte_mem.sv
// L2 byte buffer
// Byte-wide 4 KB array with one 32-bit read port and one 32-bit write port,
// little-endian, addresses wrap at the end of the buffer

`default_nettype none

`include "udma_defines.svh"

module l2_byte_mem (
    input  wire logic               sys_clk,
    input  wire udma_pkg::l2_addr_t raddr_i,
    output udma_pkg::word_t         rdata_o,
    input  wire logic               we_i,
    input  wire udma_pkg::l2_addr_t waddr_i,
    input  wire udma_pkg::word_t    wdata_i
);

    logic [7:0] mem [0:`UDMA_L2_DEPTH-1];

    //////////////////////////////
    // Read port
    //////////////////////////////

    // Asynchronous, lowest address lands in bits 7:0
    always_comb begin
        for (int b = 0; b < 4; b++) begin
            rdata_o[8*b +: 8] = mem[udma_pkg::l2_addr_t'(raddr_i + b)];  // Wraps at 4 KB
        end
    end

    //////////////////////////////
    // Write port
    //////////////////////////////

    always_ff @(posedge sys_clk) begin
        if (we_i) begin
            for (int b = 0; b < 4; b++) begin
                mem[udma_pkg::l2_addr_t'(waddr_i + b)] <= wdata_i[8*b +: 8];
            end
        end
    end

endmodule

`default_nettype wire

// File: rtl/udma_cfg_regs.sv
// uDMA configuration registers
// Decodes the register map, stores start addresses and sizes, issues the
// channel enable pulses and muxes the readback

`default_nettype none

`include "udma_defines.svh"

module udma_cfg_regs (
    input  wire logic        sys_clk,
    input  wire logic        rst_n,
    input  wire logic [4:0]  cfg_addr_i,
    input  wire logic [31:0] cfg_data_i,
    input  wire logic        cfg_valid_i,
    input  wire logic        cfg_rwn_i,
    output logic      [31:0] cfg_data_o,
    udma_chan_if.regs        tx_chan,
    udma_chan_if.regs        rx_chan
);

    udma_pkg::cfg_reg_e   reg_sel;
    logic                 wr_strobe;

    udma_pkg::l2_addr_t   tx_saddr_q;
    udma_pkg::xfer_size_t tx_size_q;
    logic                 tx_en_q;
    udma_pkg::l2_addr_t   rx_saddr_q;
    udma_pkg::xfer_size_t rx_size_q;
    logic                 rx_en_q;

    assign reg_sel   = udma_pkg::cfg_reg_e'(cfg_addr_i);
    assign wr_strobe = cfg_valid_i & ~cfg_rwn_i;

    //////////////////////////////
    // Register writes
    //////////////////////////////

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            tx_saddr_q <= '0;
            tx_size_q  <= '0;
            tx_en_q    <= 1'b0;
            rx_saddr_q <= '0;
            rx_size_q  <= '0;
            rx_en_q    <= 1'b0;
        end else begin
            tx_en_q <= 1'b0;  // Enables are single pulses
            rx_en_q <= 1'b0;
            if (wr_strobe) begin
                case (reg_sel)
                    udma_pkg::REG_TX_SADDR: tx_saddr_q <= cfg_data_i[`UDMA_L2_AW-1:0];
                    udma_pkg::REG_TX_SIZE:  tx_size_q  <= cfg_data_i[`UDMA_SIZE_W-1:0];
                    udma_pkg::REG_RX_SADDR: rx_saddr_q <= cfg_data_i[`UDMA_L2_AW-1:0];
                    udma_pkg::REG_RX_SIZE:  rx_size_q  <= cfg_data_i[`UDMA_SIZE_W-1:0];
                    udma_pkg::REG_UDMA_TXCFG: begin
                        // Dropped while the channel is running or about to start
                        tx_en_q <= cfg_data_i[`UDMA_CFG_EN_BIT] & ~tx_chan.busy & ~tx_en_q
                                   & (tx_size_q != '0);
                    end
                    udma_pkg::REG_UDMA_RXCFG: begin
                        rx_en_q <= cfg_data_i[`UDMA_CFG_EN_BIT] & ~rx_chan.busy & ~rx_en_q
                                   & (rx_size_q != '0);
                    end
                    default: ;  // Status and unmapped are read only
                endcase
            end
        end
    end

    assign tx_chan.start_addr = tx_saddr_q;
    assign tx_chan.size       = tx_size_q;
    assign tx_chan.en         = tx_en_q;
    assign rx_chan.start_addr = rx_saddr_q;
    assign rx_chan.size       = rx_size_q;
    assign rx_chan.en         = rx_en_q;

    //////////////////////////////
    // Readback
    //////////////////////////////

    always_comb begin
        cfg_data_o = '0;
        case (reg_sel)
            udma_pkg::REG_RX_SADDR:   cfg_data_o[`UDMA_L2_AW-1:0]  = rx_saddr_q;
            udma_pkg::REG_RX_SIZE:    cfg_data_o[`UDMA_SIZE_W-1:0] = rx_size_q;
            udma_pkg::REG_UDMA_RXCFG: cfg_data_o[`UDMA_CFG_EN_BIT] = rx_chan.busy;
            udma_pkg::REG_TX_SADDR:   cfg_data_o[`UDMA_L2_AW-1:0]  = tx_saddr_q;
            udma_pkg::REG_TX_SIZE:    cfg_data_o[`UDMA_SIZE_W-1:0] = tx_size_q;
            udma_pkg::REG_UDMA_TXCFG: cfg_data_o[`UDMA_CFG_EN_BIT] = tx_chan.busy;
            udma_pkg::REG_STATUS:     cfg_data_o = {rx_chan.bytes_left, tx_chan.bytes_left};
            default: ;
        endcase
    end

    // An engine must never see a start while it is still running
    a_tx_en_idle: assert property (@(posedge sys_clk) disable iff (!rst_n)
        !(tx_chan.en && tx_chan.busy));
    a_rx_en_idle: assert property (@(posedge sys_clk) disable iff (!rst_n)
        !(rx_chan.en && rx_chan.busy));

endmodule

`default_nettype wire

// File: rtl/udma_chan_if.sv
// uDMA channel interface
// Carries one channel's configuration to its engine and status back

`default_nettype none

interface udma_chan_if;

    udma_pkg::l2_addr_t   start_addr;  // Programmed L2 start address
    udma_pkg::xfer_size_t size;        // Programmed transfer size
    logic                 en;          // One-cycle start pulse

    logic                 busy;        // Transfer in progress
    udma_pkg::xfer_size_t bytes_left;  // Remaining bytes of the transfer

    // Register file side
    modport regs (
        output start_addr,
        output size,
        output en,
        input  busy,
        input  bytes_left
    );

    // DMA engine side
    modport engine (
        input  start_addr,
        input  size,
        input  en,
        output busy,
        output bytes_left
    );

endinterface

`default_nettype wire

// File: rtl/udma_defines.svh
// uDMA channel defines
// Sizes of the L2 buffer, the transfer counters and the config enable bit

`ifndef UDMA_DEFINES_SVH
`define UDMA_DEFINES_SVH

//////////////////////////////
// L2 buffer
//////////////////////////////

// Byte address width of the L2 buffer
`define UDMA_L2_AW 12

// L2 buffer size in bytes
`define UDMA_L2_DEPTH 4096

//////////////////////////////
// Transfer control
//////////////////////////////

// Width of a transfer size and a bytes-left count
`define UDMA_SIZE_W 16

// Enable bit in the TX and RX config registers
`define UDMA_CFG_EN_BIT 4

`endif

// File: rtl/udma_pkg.sv
// uDMA package
// Register map, engine states and the common data types

`default_nettype none

`include "udma_defines.svh"

package udma_pkg;

    //////////////////////////////
    // Register map
    //////////////////////////////

    typedef enum logic [4:0] {
        REG_RX_SADDR   = 5'd0,  // L2 start address for RX
        REG_RX_SIZE    = 5'd1,  // RX size in bytes
        REG_UDMA_RXCFG = 5'd2,  // RX enable
        REG_TX_SADDR   = 5'd3,  // L2 start address for TX
        REG_TX_SIZE    = 5'd4,  // TX size in bytes
        REG_UDMA_TXCFG = 5'd5,  // TX enable
        REG_STATUS     = 5'd9   // Bytes left of both channels
    } cfg_reg_e;

    // Shared by the TX and RX engines
    typedef enum logic {
        ST_IDLE   = 1'b0,
        ST_STREAM = 1'b1
    } stream_state_e;

    typedef logic [`UDMA_L2_AW-1:0]  l2_addr_t;    // L2 byte address
    typedef logic [`UDMA_SIZE_W-1:0] xfer_size_t;  // Byte count
    typedef logic [31:0]             word_t;

endpackage

`default_nettype wire

// File: rtl/udma_rx_stream.sv
// uDMA RX engine
// Writes strobed incoming words into L2 at consecutive word addresses

`default_nettype none

module udma_rx_stream (
    input  wire logic               sys_clk,
    input  wire logic               rst_n,
    input  wire udma_pkg::word_t    rx_data_i,
    input  wire logic               rx_valid_i,
    udma_chan_if.engine             chan,
    output logic                    mem_we_o,
    output udma_pkg::l2_addr_t      mem_waddr_o,
    output udma_pkg::word_t         mem_wdata_o,
    output logic                    rx_eot_o
);

    localparam udma_pkg::xfer_size_t WORD_BYTES = 4;

    udma_pkg::stream_state_e state_q;
    udma_pkg::l2_addr_t      addr_q;
    udma_pkg::xfer_size_t    bytes_left_q;

    assign chan.busy       = (state_q == udma_pkg::ST_STREAM);
    assign chan.bytes_left = bytes_left_q;

    // Strobes outside a transfer never reach L2
    assign mem_we_o    = rx_valid_i && (state_q == udma_pkg::ST_STREAM);
    assign mem_waddr_o = addr_q;
    assign mem_wdata_o = rx_data_i;

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= udma_pkg::ST_IDLE;
            addr_q       <= '0;
            bytes_left_q <= '0;
            rx_eot_o     <= 1'b0;
        end else begin
            rx_eot_o <= 1'b0;
            case (state_q)
                udma_pkg::ST_IDLE: begin
                    if (chan.en) begin
                        state_q      <= udma_pkg::ST_STREAM;
                        addr_q       <= chan.start_addr;
                        bytes_left_q <= chan.size;
                    end
                end
                udma_pkg::ST_STREAM: begin
                    if (mem_we_o) begin
                        addr_q <= addr_q + udma_pkg::l2_addr_t'(WORD_BYTES);  // Wraps
                        if (bytes_left_q > WORD_BYTES) begin
                            bytes_left_q <= bytes_left_q - WORD_BYTES;
                        end else begin
                            bytes_left_q <= '0;   // Saturates on a short last word
                            rx_eot_o     <= 1'b1;
                            state_q      <= udma_pkg::ST_IDLE;
                        end
                    end
                end
                default: state_q <= udma_pkg::ST_IDLE;
            endcase
        end
    end

    // No L2 write once the programmed size is used up
    a_rx_we_in_size: assert property (@(posedge sys_clk) disable iff (!rst_n)
        mem_we_o |-> bytes_left_q != '0);

endmodule

`default_nettype wire

// File: rtl/udma_tx_stream.sv
// uDMA TX engine
// Fetches 32-bit words from L2 and streams them out under valid/ready

`default_nettype none

module udma_tx_stream (
    input  wire logic               sys_clk,
    input  wire logic               rst_n,
    udma_chan_if.engine             chan,
    output udma_pkg::l2_addr_t      mem_raddr_o,
    input  wire udma_pkg::word_t    mem_rdata_i,
    input  wire logic               tx_ready_i,
    output udma_pkg::word_t         tx_data_o,
    output logic                    tx_valid_o,
    output logic                    tx_eot_o
);

    localparam udma_pkg::xfer_size_t WORD_BYTES = 4;

    udma_pkg::stream_state_e state_q;
    udma_pkg::l2_addr_t      addr_q;        // Next word to fetch
    udma_pkg::xfer_size_t    bytes_left_q;
    logic                    load_word;

    assign mem_raddr_o     = addr_q;
    assign chan.busy       = (state_q == udma_pkg::ST_STREAM);
    assign chan.bytes_left = bytes_left_q;

    // First fetch, or a handshake with more words still to come
    assign load_word = (state_q == udma_pkg::ST_STREAM)
                       && (!tx_valid_o || (tx_ready_i && bytes_left_q > WORD_BYTES));

    always_ff @(posedge sys_clk or negedge rst_n) begin
        if (!rst_n) begin
            state_q      <= udma_pkg::ST_IDLE;
            addr_q       <= '0;
            bytes_left_q <= '0;
            tx_valid_o   <= 1'b0;
            tx_eot_o     <= 1'b0;
        end else begin
            tx_eot_o <= 1'b0;
            case (state_q)
                udma_pkg::ST_IDLE: begin
                    if (chan.en) begin
                        state_q      <= udma_pkg::ST_STREAM;
                        addr_q       <= chan.start_addr;
                        bytes_left_q <= chan.size;
                    end
                end
                udma_pkg::ST_STREAM: begin
                    if (load_word) begin
                        addr_q     <= addr_q + udma_pkg::l2_addr_t'(WORD_BYTES);  // Wraps
                        tx_valid_o <= 1'b1;
                    end
                    if (tx_valid_o && tx_ready_i) begin
                        if (bytes_left_q > WORD_BYTES) begin
                            bytes_left_q <= bytes_left_q - WORD_BYTES;
                        end else begin
                            bytes_left_q <= '0;              // Last word accepted
                            tx_valid_o   <= 1'b0;
                            tx_eot_o     <= 1'b1;
                            state_q      <= udma_pkg::ST_IDLE;
                        end
                    end
                end
                default: state_q <= udma_pkg::ST_IDLE;
            endcase
        end
    end

    // Output word register
    always_ff @(posedge sys_clk) begin
        if (load_word) begin
            tx_data_o <= mem_rdata_i;
        end
    end

    a_tx_hold: assert property (@(posedge sys_clk) disable iff (!rst_n)
        tx_valid_o && !tx_ready_i |=> tx_valid_o && $stable(tx_data_o));

endmodule

`default_nettype wire

// File: sim.f
+incdir+rtl
rtl/udma_pkg.sv
rtl/udma_chan_if.sv
rtl/l2_byte_mem.sv
rtl/udma_cfg_regs.sv
rtl/udma_tx_stream.sv
rtl/udma_rx_stream.sv
rtl/hyper_udma_chan.sv
test/tb_hyper_udma_chan.sv

// File: test/tb_hyper_udma_chan.sv
// Testbench for the HyperBus uDMA channel front end
// Fills L2 through the RX engine, streams it back through the TX engine
// and checks every TX word against a byte-wide shadow of L2

`default_nettype none

`include "udma_defines.svh"

module tb_hyper_udma_chan;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int TIMEOUT_CYCLES = 1000;
    localparam logic [31:0] EN_MASK = 32'h1 << `UDMA_CFG_EN_BIT;

    logic        sys_clk;
    logic        rst_n;
    logic [4:0]  cfg_addr_i;
    logic [31:0] cfg_data_i;
    logic        cfg_valid_i;
    logic        cfg_rwn_i;
    logic [31:0] cfg_data_o;
    logic [31:0] tx_data_o;
    logic        tx_valid_o;
    logic        tx_ready_i;
    logic        tx_eot_o;
    logic [31:0] rx_data_i;
    logic        rx_valid_i;
    logic        rx_eot_o;

    logic [7:0]  shadow [0:`UDMA_L2_DEPTH-1];  // Expected L2 contents
    logic [31:0] lfsr_state = 32'hc439_ad02;
    logic [11:0] tx_base;
    int          tx_words;
    int          tx_count;
    logic        hold_prev;
    logic [31:0] prev_data;

    hyper_udma_chan hyper_udma_chan_i (.*);

    always #5 sys_clk = ~sys_clk;

    //////////////////////////////
    // Helpers
    //////////////////////////////

    // Galois LFSR, one step per random bit
    function automatic logic [31:0] take_random(input int nbits);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < nbits; i++) begin
            r[i] = lfsr_state[0];
            lfsr_state = (lfsr_state >> 1) ^ (lfsr_state[0] ? 32'h8020_0003 : 32'h0);
        end
        return r;
    endfunction

    // Word k of a transfer from base, built from the shadow bytes
    function automatic logic [31:0] expected_word(input logic [11:0] base, input int k);
        logic [11:0] a;
        logic [31:0] w;
        a = base + 12'(4 * k);  // Wraps at 4 KB
        for (int b = 0; b < 4; b++) begin
            w[8*b +: 8] = shadow[12'(a + 12'(b))];
        end
        return w;
    endfunction

    task automatic fail_run(input string reason);
        $display("%s", reason);
        $display("Simulation failed");
        $fatal(1, "run stopped");
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (actual !== expected) begin
            fail_run($sformatf("[FAIL] %s expected %h actual %h", name, expected, actual));
        end
    endtask

    task automatic cfg_write(input logic [4:0] addr, input logic [31:0] data);
        @(negedge sys_clk);
        cfg_addr_i  = addr;
        cfg_data_i  = data;
        cfg_valid_i = 1'b1;
        cfg_rwn_i   = 1'b0;
        @(negedge sys_clk);
        cfg_valid_i = 1'b0;
        cfg_rwn_i   = 1'b1;
    endtask

    task automatic cfg_read(input logic [4:0] addr, output logic [31:0] data);
        @(negedge sys_clk);
        cfg_addr_i = addr;
        @(posedge sys_clk);
        data = cfg_data_o;  // Combinational readback
    endtask

    //////////////////////////////
    // TX monitor
    //////////////////////////////

    always @(posedge sys_clk) begin
        if (rst_n) begin
            if (hold_prev) begin
                check_value("tx valid held under back-pressure", 1, tx_valid_o);
                check_value("tx data held under back-pressure", prev_data, tx_data_o);
            end
            if (tx_valid_o && tx_ready_i) begin
                if (tx_count >= tx_words) begin
                    fail_run("TX sent more words than the programmed size allows");
                end else begin
                    check_value($sformatf("tx word %0d", tx_count),
                                expected_word(tx_base, tx_count), tx_data_o);
                    tx_count++;
                end
            end
            hold_prev = tx_valid_o && !tx_ready_i;
            prev_data = tx_data_o;
        end
    end

    //////////////////////////////
    // Transfers
    //////////////////////////////

    task automatic run_rx(input logic [11:0] saddr, input logic [15:0] size,
                          input bit extra_strobe);
        logic [31:0] d;
        logic [31:0] w;
        int          n;
        bit          busy_seen;
        n = (size + 3) / 4;
        cfg_write(udma_pkg::REG_RX_SADDR, 32'(saddr));
        cfg_write(udma_pkg::REG_RX_SIZE, 32'(size));
        cfg_write(udma_pkg::REG_UDMA_RXCFG, EN_MASK);
        busy_seen = 1'b0;
        for (int c = 0; c < TIMEOUT_CYCLES && !busy_seen; c++) begin
            cfg_read(udma_pkg::REG_UDMA_RXCFG, d);
            busy_seen = d[`UDMA_CFG_EN_BIT];
        end
        if (!busy_seen) begin
            fail_run("Timed out waiting for the RX channel to become busy");
        end
        for (int i = 0; i < n; i++) begin
            @(negedge sys_clk);
            w = take_random(32);
            rx_data_i  = w;
            rx_valid_i = 1'b1;
            for (int b = 0; b < 4; b++) begin
                shadow[12'(saddr + 12'(4 * i) + 12'(b))] = w[8*b +: 8];
            end
            @(posedge sys_clk);
            check_value("rx eot before the last word", 0, rx_eot_o);
        end
        @(negedge sys_clk);
        rx_valid_i = 1'b0;
        @(posedge sys_clk);
        check_value("rx eot after the last word", 1, rx_eot_o);
        cfg_read(udma_pkg::REG_STATUS, d);
        check_value("rx bytes left", 0, 32'(d[31:16]));
        if (extra_strobe) begin
            @(negedge sys_clk);
            rx_data_i  = take_random(32);  // Must not reach L2
            rx_valid_i = 1'b1;
            @(negedge sys_clk);
            rx_valid_i = 1'b0;
            @(posedge sys_clk);
            check_value("rx eot on an idle strobe", 0, rx_eot_o);
        end
        cfg_read(udma_pkg::REG_UDMA_RXCFG, d);
        check_value("rx busy after transfer", 0, d);
    endtask

    task automatic run_tx(input logic [11:0] saddr, input logic [15:0] size,
                          input bit poke_busy);
        logic [31:0] d;
        bit          done;
        cfg_write(udma_pkg::REG_TX_SADDR, 32'(saddr));
        cfg_write(udma_pkg::REG_TX_SIZE, 32'(size));
        tx_base  = saddr;
        tx_words = (size + 3) / 4;
        tx_count = 0;
        cfg_write(udma_pkg::REG_UDMA_TXCFG, EN_MASK);
        cfg_addr_i = udma_pkg::REG_UDMA_TXCFG;
        cfg_data_i = EN_MASK;
        done = 1'b0;
        for (int c = 0; c < TIMEOUT_CYCLES && !done; c++) begin
            tx_ready_i  = 1'(take_random(1));
            cfg_valid_i = poke_busy && c == 3;  // Second enable while running
            cfg_rwn_i   = !cfg_valid_i;
            @(posedge sys_clk);
            if (poke_busy && c == 5) begin
                check_value("txcfg enable bit while busy", EN_MASK, cfg_data_o);
            end
            if (tx_eot_o) begin
                check_value("tx valid at eot", 0, tx_valid_o);
                check_value("tx word count", tx_words, tx_count);
                done = 1'b1;
            end
            @(negedge sys_clk);
        end
        if (!done) begin
            fail_run("Timed out waiting for the TX end of transfer");
        end
        tx_ready_i = 1'b0;
        @(posedge sys_clk);
        check_value("tx eot pulse width", 0, tx_eot_o);
        cfg_read(udma_pkg::REG_STATUS, d);
        check_value("tx bytes left", 0, 32'(d[15:0]));
        cfg_read(udma_pkg::REG_UDMA_TXCFG, d);
        check_value("tx busy after transfer", 0, d);
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////

    initial begin
        logic [31:0] d;
        sys_clk     = 1'b0;
        rst_n       = 1'b0;
        cfg_addr_i  = '0;
        cfg_data_i  = '0;
        cfg_valid_i = 1'b0;
        cfg_rwn_i   = 1'b1;
        tx_ready_i  = 1'b0;
        rx_data_i   = '0;
        rx_valid_i  = 1'b0;
        tx_base     = '0;
        tx_words    = 0;
        tx_count    = 0;
        hold_prev   = 1'b0;
        prev_data   = '0;
        repeat (4) @(posedge sys_clk);
        @(negedge sys_clk);
        rst_n = 1'b1;

        check_value("tx valid after reset", 0, tx_valid_o);
        check_value("tx eot after reset", 0, tx_eot_o);
        check_value("rx eot after reset", 0, rx_eot_o);
        for (int a = 0; a < 32; a++) begin
            cfg_read(5'(a), d);
            check_value($sformatf("reg %0d after reset", a), 0, d);
        end

        cfg_write(udma_pkg::REG_TX_SADDR, 32'h0000_0abc);
        cfg_write(udma_pkg::REG_TX_SIZE, 32'h0000_1234);
        cfg_write(udma_pkg::REG_RX_SADDR, 32'h0000_0567);
        cfg_write(udma_pkg::REG_RX_SIZE, 32'h0000_00f0);
        cfg_read(udma_pkg::REG_TX_SADDR, d);
        check_value("tx saddr readback", 32'h0000_0abc, d);
        cfg_read(udma_pkg::REG_TX_SIZE, d);
        check_value("tx size readback", 32'h0000_1234, d);
        cfg_read(udma_pkg::REG_RX_SADDR, d);
        check_value("rx saddr readback", 32'h0000_0567, d);
        cfg_read(udma_pkg::REG_RX_SIZE, d);
        check_value("rx size readback", 32'h0000_00f0, d);

        run_rx(12'h100, 16'd32, 1'b0);    // Known data behind the short transfer
        run_rx(12'h100, 16'd22, 1'b1);    // Six words, then an idle strobe
        run_tx(12'h100, 16'd28, 1'b0);
        run_rx(12'd4088, 16'd16, 1'b0);   // Crosses the top of L2
        run_tx(12'd4092, 16'd12, 1'b0);
        run_tx(12'h100, 16'd32, 1'b1);

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

`default_nettype wire
